// ==== Makefile ====
# Verilator build and run of the audio path testbench

SOURCES := $(filter-out +%,$(shell cat filelist.f))

.PHONY: run clean

run: obj_dir/Vtb_audio_top
	./obj_dir/Vtb_audio_top | tee sim.log
	grep -qx "Test completed successfully" sim.log

obj_dir/Vtb_audio_top: $(SOURCES) tb_audio_ref.svh filelist.f
	verilator --binary --assert --top-module tb_audio_top -f filelist.f -o Vtb_audio_top

clean:
	rm -rf obj_dir sim.log

// ==== audio_attenuate.sv ====
// Source attenuation stage
// Scales tone and ADPCM by fixed ratios, delays CD audio by the same cycle

`timescale 1ns/10ps

module audio_attenuate (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              psg_en,
	input  logic              adpcm_en,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t adpcm,
	output audio_pkg::sample_t cdda_l_d,
	output audio_pkg::sample_t cdda_r_d,
	output audio_pkg::sample_t psg_l_red,
	output audio_pkg::sample_t psg_r_red,
	output audio_pkg::sample_t adpcm_red
);

	// Tone channels at 13/16
	function automatic audio_pkg::sample_t reduce_psg(input audio_pkg::sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 4);
	endfunction

	// ADPCM at 7/8
	function automatic audio_pkg::sample_t reduce_adpcm(input audio_pkg::sample_t s);
		return (s >>> 1) + (s >>> 2) + (s >>> 3);
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cdda_l_d  <= '0;
			cdda_r_d  <= '0;
			psg_l_red <= '0;
			psg_r_red <= '0;
			adpcm_red <= '0;
		end else begin
			// CD audio passes unchanged, gated later in the mixer
			cdda_l_d  <= cdda_l;
			cdda_r_d  <= cdda_r;
			psg_l_red <= psg_en ? reduce_psg(psg_l) : '0;
			psg_r_red <= psg_en ? reduce_psg(psg_r) : '0;
			adpcm_red <= adpcm_en ? reduce_adpcm(adpcm) : '0;
		end
	end

endmodule

// ==== audio_compressor.sv ====
// Master boost compressor
// Two-knee gain curve on the sample magnitude, or pass-through, registered per side

`timescale 1ns/10ps

module audio_compressor (
	input  logic               clk_sys,
	input  logic               reset,
	input  audio_pkg::boost_t  mboost,
	input  audio_pkg::sample_t mix_l,
	input  audio_pkg::sample_t mix_r,
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r
);

	// One curve segment pair: linear gain below the knee, flattened above
	function automatic audio_pkg::mag_t curve(
		input audio_pkg::mag_t mag,
		input audio_pkg::mag_t knee,
		input audio_pkg::mag_t gain,
		input audio_pkg::mag_t div,
		input audio_pkg::mag_t base
	);
		audio_pkg::mag_t res;
		if (mag < knee) begin
			res = mag * gain;
		end else begin
			res = ((mag - knee) / div) + base;
		end
		return res;
	endfunction

	function automatic audio_pkg::sample_t compress(
		input audio_pkg::sample_t s,
		input audio_pkg::boost_t  sel
	);
		audio_pkg::mag_t mag;
		audio_pkg::mag_t res;
		// Full-scale negative gives 0x8000, still a valid magnitude
		mag = s[audio_pkg::SAMPLE_W-1] ? audio_pkg::mag_t'(-s) : audio_pkg::mag_t'(s);
		if (sel[1]) begin
			res = curve(mag, audio_pkg::COMP2_KNEE, audio_pkg::COMP2_GAIN,
				audio_pkg::COMP2_DIV, audio_pkg::COMP2_BASE);
		end else begin
			res = curve(mag, audio_pkg::COMP1_KNEE, audio_pkg::COMP1_GAIN,
				audio_pkg::COMP1_DIV, audio_pkg::COMP1_BASE);
		end
		// Restore sign
		return s[audio_pkg::SAMPLE_W-1] ? audio_pkg::sample_t'(-res)
			: audio_pkg::sample_t'(res);
	endfunction

	logic comp_on;

	assign comp_on = (mboost != 2'd0);

	////////////////////
	// Output register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (comp_on) begin
			audio_l <= compress(mix_l, mboost);
			audio_r <= compress(mix_r, mboost);
		end else begin
			audio_l <= mix_l;
			audio_r <= mix_r;
		end
	end

endmodule

// ==== audio_ctrl_regs.sv ====
// Audio control register
// Wishbone classic slave with one control byte, split into the audio path settings

`timescale 1ns/10ps

module audio_ctrl_regs #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [ADDR_WIDTH-1:0] wb_adr,
	input  wb_pkg::wb_data_t      wb_dat_w,
	input  logic [3:0]            wb_sel,
	output wb_pkg::wb_data_t      wb_dat_r,
	output logic                  wb_ack,

	output logic                  cdda_boost,
	output audio_pkg::boost_t     mboost,
	output logic                  psg_en,
	output logic                  cdda_en,
	output logic                  adpcm_en
);

	wb_pkg::ctrl_t ctrl;
	logic          req;
	logic          hit;

	// New request only while no ack is out, so every access acks once
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign hit = (wb_adr == ADDR_WIDTH'(wb_pkg::CTRL_OFFSET));

	////////////////////
	// Handshake and register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wb_ack <= 1'b0;
			ctrl   <= wb_pkg::CTRL_RESET;
		end else begin
			wb_ack <= req;
			// Only byte lane 0 carries fields
			if (req && wb_we && hit && wb_sel[0]) begin
				ctrl <= wb_dat_w[7:0];
			end
		end
	end

	// Read data is valid together with ack
	always_ff @(posedge clk_sys) begin
		if (req && !wb_we) begin
			wb_dat_r <= hit ? wb_pkg::wb_data_t'(ctrl) : '0;
		end
	end

	////////////////////
	// Field split
	assign cdda_boost = ctrl[wb_pkg::CTRL_CDDA_BOOST_BIT];
	assign mboost     = ctrl[wb_pkg::CTRL_MBOOST_LSB +: 2];
	assign psg_en     = ctrl[wb_pkg::CTRL_PSG_EN_BIT];
	assign cdda_en    = ctrl[wb_pkg::CTRL_CDDA_EN_BIT];
	assign adpcm_en   = ctrl[wb_pkg::CTRL_ADPCM_EN_BIT];

endmodule

// ==== audio_mixer.sv ====
// Stereo mixer
// Sums all sources per side in 18 bits, then applies either CD boost or 5/4 range gain

`timescale 1ns/10ps

module audio_mixer (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               cdda_en,
	input  logic               cdda_boost,
	input  audio_pkg::sample_t cdda_l,
	input  audio_pkg::sample_t cdda_r,
	input  audio_pkg::sample_t psg_l,
	input  audio_pkg::sample_t psg_r,
	input  audio_pkg::sample_t adpcm,
	output audio_pkg::sample_t mix_l,
	output audio_pkg::sample_t mix_r
);

	localparam int EXT_W = audio_pkg::MIX_W - audio_pkg::SAMPLE_W;

	audio_pkg::mix_t sum_l;
	audio_pkg::mix_t sum_r;
	audio_pkg::mix_t gain_l;
	audio_pkg::mix_t gain_r;
	// Boost setting that travels with the sum
	logic            boost_d;

	function automatic audio_pkg::mix_t sext(input audio_pkg::sample_t s);
		return {{EXT_W{s[audio_pkg::SAMPLE_W-1]}}, s};
	endfunction

	// CD counts once, twice when boosted, never when disabled
	function automatic audio_pkg::mix_t side_sum(
		input audio_pkg::sample_t cd,
		input audio_pkg::sample_t tone,
		input audio_pkg::sample_t pcm,
		input logic               cd_on,
		input logic               cd_twice
	);
		audio_pkg::mix_t cd_x;
		cd_x = cd_on ? sext(cd) : '0;
		return cd_x + (cd_twice ? cd_x : '0) + sext(tone) + sext(pcm);
	endfunction

	////////////////////
	// Stage one, gated sum
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_l   <= '0;
			sum_r   <= '0;
			boost_d <= 1'b0;
		end else begin
			sum_l   <= side_sum(cdda_l, psg_l, adpcm, cdda_en, cdda_boost);
			sum_r   <= side_sum(cdda_r, psg_r, adpcm, cdda_en, cdda_boost);
			boost_d <= cdda_boost;
		end
	end

	////////////////////
	// Stage two, gain
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gain_l <= '0;
			gain_r <= '0;
		end else if (boost_d) begin
			gain_l <= sum_l;
			gain_r <= sum_r;
		end else begin
			// Add a quarter to use the full range
			gain_l <= sum_l + (sum_l >>> 2);
			gain_r <= sum_r + (sum_r >>> 2);
		end
	end

	assign mix_l = gain_l[audio_pkg::MIX_W-1:EXT_W];
	assign mix_r = gain_r[audio_pkg::MIX_W-1:EXT_W];

endmodule

// ==== audio_pkg.sv ====
// Audio path definitions
// Sample and mix widths, plus the knee constants of the two compressor curves

package audio_pkg;

	localparam int SAMPLE_W = 16;
	localparam int MIX_W    = 18;

	// Signed PCM sample, same format on every input and output
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Per-side accumulator, two guard bits above a sample
	typedef logic signed [MIX_W-1:0] mix_t;

	// Unsigned magnitude used inside the compressor
	typedef logic [SAMPLE_W-1:0] mag_t;

	// Master boost: 0 off, 1 the 2x curve, 2 or 3 the 4x curve
	typedef logic [1:0] boost_t;

	////////////////////
	// 2x curve
	localparam mag_t COMP1_KNEE = 16'd14044;
	localparam mag_t COMP1_GAIN = 16'd2;
	localparam mag_t COMP1_DIV  = 16'd4;
	// Knee times gain, so both segments meet
	localparam mag_t COMP1_BASE = 16'd28088;

	////////////////////
	// 4x curve
	localparam mag_t COMP2_KNEE = 16'd7399;
	localparam mag_t COMP2_GAIN = 16'd4;
	localparam mag_t COMP2_DIV  = 16'd8;
	localparam mag_t COMP2_BASE = 16'd29596;

	// Attenuate 1 + mixer 2 + compressor 1
	localparam int PIPE_LATENCY = 4;

endpackage

// ==== audio_top.sv ====
// Audio path top level
// Control register plus attenuate, mix and compress stages, 4 samples deep

`timescale 1ns/10ps

module audio_top #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [ADDR_WIDTH-1:0] wb_adr,
	input  wb_pkg::wb_data_t      wb_dat_w,
	input  logic [3:0]            wb_sel,
	output wb_pkg::wb_data_t      wb_dat_r,
	output logic                  wb_ack,

	input  audio_pkg::sample_t    cdda_l,
	input  audio_pkg::sample_t    cdda_r,
	input  audio_pkg::sample_t    psg_l,
	input  audio_pkg::sample_t    psg_r,
	input  audio_pkg::sample_t    adpcm,
	output audio_pkg::sample_t    audio_l,
	output audio_pkg::sample_t    audio_r
);

	logic               cdda_boost;
	audio_pkg::boost_t  mboost;
	logic               psg_en;
	logic               cdda_en;
	logic               adpcm_en;

	audio_pkg::sample_t cdda_l_d;
	audio_pkg::sample_t cdda_r_d;
	audio_pkg::sample_t psg_l_red;
	audio_pkg::sample_t psg_r_red;
	audio_pkg::sample_t adpcm_red;
	audio_pkg::sample_t mix_l;
	audio_pkg::sample_t mix_r;

	audio_ctrl_regs #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_ctrl (
		.clk_sys(clk_sys), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.cdda_boost(cdda_boost), .mboost(mboost),
		.psg_en(psg_en), .cdda_en(cdda_en), .adpcm_en(adpcm_en)
	);

	////////////////////
	// Pipeline, latency PIPE_LATENCY
	// Cycle 1
	audio_attenuate u_atten (
		.clk_sys(clk_sys), .reset(reset),
		.psg_en(psg_en), .adpcm_en(adpcm_en),
		.cdda_l(cdda_l), .cdda_r(cdda_r), .psg_l(psg_l), .psg_r(psg_r), .adpcm(adpcm),
		.cdda_l_d(cdda_l_d), .cdda_r_d(cdda_r_d),
		.psg_l_red(psg_l_red), .psg_r_red(psg_r_red), .adpcm_red(adpcm_red)
	);

	// Cycles 2 and 3
	audio_mixer u_mixer (
		.clk_sys(clk_sys), .reset(reset),
		.cdda_en(cdda_en), .cdda_boost(cdda_boost),
		.cdda_l(cdda_l_d), .cdda_r(cdda_r_d),
		.psg_l(psg_l_red), .psg_r(psg_r_red), .adpcm(adpcm_red),
		.mix_l(mix_l), .mix_r(mix_r)
	);

	// Cycle 4
	audio_compressor u_comp (
		.clk_sys(clk_sys), .reset(reset), .mboost(mboost),
		.mix_l(mix_l), .mix_r(mix_r),
		.audio_l(audio_l), .audio_r(audio_r)
	);

endmodule

// ==== filelist.f ====
+incdir+.
audio_pkg.sv
wb_pkg.sv
audio_ctrl_regs.sv
audio_attenuate.sv
audio_mixer.sv
audio_compressor.sv
audio_top.sv
tb_audio_top.sv

// ==== tb_audio_ref.svh ====
// Reference model of the audio path
// Attenuation, per-side mix and gain, and the master boost curves in integer arithmetic

`ifndef TB_AUDIO_REF_SVH
`define TB_AUDIO_REF_SVH

// Rounds toward minus infinity, like an arithmetic right shift
function automatic int floor_div_pow2(input int v, input int n);
	int d;
	d = 1 << n;
	return (v >= 0) ? v / d : -((d - 1 - v) / d);
endfunction

// Linear gain below the knee, flattened slope from the knee up
function automatic int curve_point(input int mag, input int knee, input int gain,
	input int div, input int base);
	return (mag < knee) ? mag * gain : (mag - knee) / div + base;
endfunction

// Output sample of one side for a control byte and that side's inputs
function automatic audio_pkg::sample_t ref_side(input wb_pkg::ctrl_t c, input int cd,
	input int tone, input int pcm);
	int sum;
	int mix;
	int mag;
	int res;
	audio_pkg::boost_t mb;
	mb = c[wb_pkg::CTRL_MBOOST_LSB +: 2];
	sum = 0;
	if (c[wb_pkg::CTRL_CDDA_EN_BIT])
		sum = c[wb_pkg::CTRL_CDDA_BOOST_BIT] ? 2 * cd : cd;
	// Tone at 1/2+1/4+1/16, ADPCM at 1/2+1/4+1/8, every term floored
	if (c[wb_pkg::CTRL_PSG_EN_BIT])
		sum += floor_div_pow2(tone, 1) + floor_div_pow2(tone, 2) + floor_div_pow2(tone, 4);
	if (c[wb_pkg::CTRL_ADPCM_EN_BIT])
		sum += floor_div_pow2(pcm, 1) + floor_div_pow2(pcm, 2) + floor_div_pow2(pcm, 3);
	// Range gain of 5/4 only without CD boost
	if (!c[wb_pkg::CTRL_CDDA_BOOST_BIT])
		sum += floor_div_pow2(sum, 2);
	mix = floor_div_pow2(sum, 2);
	mag = (mix < 0) ? -mix : mix;
	if (mb == 2'd0)
		res = mag;
	else if (mb == 2'd1)
		res = curve_point(mag, int'(audio_pkg::COMP1_KNEE), int'(audio_pkg::COMP1_GAIN),
			int'(audio_pkg::COMP1_DIV), int'(audio_pkg::COMP1_BASE));
	else
		res = curve_point(mag, int'(audio_pkg::COMP2_KNEE), int'(audio_pkg::COMP2_GAIN),
			int'(audio_pkg::COMP2_DIV), int'(audio_pkg::COMP2_BASE));
	return audio_pkg::sample_t'((mix < 0) ? -res : res);
endfunction

`endif

// ==== tb_audio_top.sv ====
// Testbench for the audio path top level
// Wishbone register checks, a table of sample sets and a streaming run

`timescale 1ns/10ps

module tb_audio_top;

	localparam int ACK_TIMEOUT = 16;
	localparam int STREAM_LEN  = 24;

	logic                     clk_sys = 1'b0;
	logic                     reset;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic [3:0]               wb_adr;
	logic [wb_pkg::SEL_W-1:0] wb_sel;
	wb_pkg::wb_data_t         wb_dat_w;
	wb_pkg::wb_data_t         wb_dat_r;
	logic                     wb_ack;
	audio_pkg::sample_t       cdda_l;
	audio_pkg::sample_t       cdda_r;
	audio_pkg::sample_t       psg_l;
	audio_pkg::sample_t       psg_r;
	audio_pkg::sample_t       adpcm;
	audio_pkg::sample_t       audio_l;
	audio_pkg::sample_t       audio_r;

	// Table rows with inputs packed as {cdda_l, cdda_r, psg_l, psg_r, adpcm}
	// and expected outputs as {left, right}
	string         names[$];
	wb_pkg::ctrl_t ctrls[$];
	logic [79:0]   ins[$];
	logic [31:0]   exps[$];

	int   passes = 0;
	int   errors = 0;
	logic timed_out = 1'b0;

	audio_top dut (.*);

	`include "tb_audio_ref.svh"

	always #4 clk_sys = ~clk_sys;

	function automatic int rand_sample();
		return int'(audio_pkg::sample_t'($urandom));
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (exp_v === act_v) begin
			passes++;
			$display("[PASS] %s", name);
		end else begin
			errors++;
			$display("[FAIL] %s expected %08h actual %08h", name, exp_v, act_v);
		end
	endtask

	// One classic cycle that also counts acks for two cycles after the first
	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [7:0] data,
		output wb_pkg::wb_data_t rdata, output int acks);
		int cycles;
		cycles = 0;
		acks = 0;
		rdata = '0;
		if (!timed_out) begin
			wb_cyc = 1'b1;
			wb_stb = 1'b1;
			wb_we = we;
			wb_adr = adr;
			wb_dat_w = 32'(data);
			while (!wb_ack && cycles < ACK_TIMEOUT) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (wb_ack) begin
				acks = 1;
				rdata = wb_dat_r;
			end else begin
				timed_out = 1'b1;
				$display("ERROR: no Wishbone ack from address %0d within %0d cycles",
					adr, ACK_TIMEOUT);
			end
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
			repeat (2) begin
				@(negedge clk_sys);
				if (wb_ack) begin
					acks++;
				end
			end
		end
	endtask

	task automatic add_entry(input string name, input wb_pkg::ctrl_t c,
		input int cl, input int cr, input int pl, input int pr, input int pcm);
		names.push_back(name);
		ctrls.push_back(c);
		ins.push_back({16'(cl), 16'(cr), 16'(pl), 16'(pr), 16'(pcm)});
		exps.push_back({ref_side(c, cl, pl, pcm), ref_side(c, cr, pr, pcm)});
	endtask

	initial begin
		wb_pkg::wb_data_t rd;
		int acks;
		int i;
		int base;
		void'($urandom(32'he06b3df9));
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '1;
		wb_dat_w = '0;
		{cdda_l, cdda_r, psg_l, psg_r, adpcm} = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		////////////////////
		// Control register
		wb_access(1'b0, 4'(wb_pkg::CTRL_OFFSET), 8'h00, rd, acks);
		check_value("reg_reset_value", 32'(wb_pkg::CTRL_RESET), rd);
		check_value("reg_reset_ack_once", 1, acks);
		wb_access(1'b1, 4'(wb_pkg::CTRL_OFFSET), 8'h2d, rd, acks);
		wb_access(1'b0, 4'(wb_pkg::CTRL_OFFSET), 8'h00, rd, acks);
		check_value("reg_write_readback", 32'h2d, rd);
		wb_access(1'b1, 4'd9, 8'hff, rd, acks);
		check_value("reg_unmapped_write_ack", 1, acks);
		wb_access(1'b0, 4'd9, 8'h00, rd, acks);
		check_value("reg_unmapped_read", 32'h0, rd);
		wb_access(1'b0, 4'(wb_pkg::CTRL_OFFSET), 8'h00, rd, acks);
		check_value("reg_unmapped_write_ignored", 32'h2d, rd);
		// Byte lane 0 disabled leaves the control byte alone
		wb_sel = 4'he;
		wb_access(1'b1, 4'(wb_pkg::CTRL_OFFSET), 8'h00, rd, acks);
		wb_sel = '1;
		wb_access(1'b0, 4'(wb_pkg::CTRL_OFFSET), 8'h00, rd, acks);
		check_value("reg_masked_write_ignored", 32'h2d, rd);

		////////////////////
		// Sample table
		// Control byte has CD boost in bit 0 and master boost in bits 2:1
		// Enables for tone, CD and ADPCM sit in bits 3, 4 and 5
		add_entry("plain_zero", 8'h38, 0, 0, 0, 0, 0);
		add_entry("plain_fixed", 8'h38, 1000, -2000, 3000, -4000, 5000);
		add_entry("plain_extreme", 8'h38, 32767, -32768, 32767, -32768, -32768);
		for (i = 0; i < 3; i++)
			add_entry($sformatf("plain_rand_%0d", i), 8'h38, rand_sample(), rand_sample(),
				rand_sample(), rand_sample(), rand_sample());
		add_entry("cd_boost_fixed", 8'h39, 1000, -2000, 3000, -4000, 5000);
		add_entry("cd_boost_max_pcm", 8'h39, 32767, -32768, 32767, -32768, 32767);
		add_entry("cd_boost_min_pcm", 8'h39, 32767, -32768, 32767, -32768, -32768);
		// CD only with boost makes the mix half the CD sample
		add_entry("comp2x_below_knee", 8'h13, 28086, -28086, 0, 0, 0);
		add_entry("comp2x_at_knee", 8'h13, 28088, -28088, 0, 0, 0);
		add_entry("comp2x_above_knee", 8'h13, 28090, -28090, 0, 0, 0);
		add_entry("comp2x_full", 8'h13, 32767, -32768, 0, 0, 0);
		add_entry("comp4x_below_knee", 8'h15, 14796, -14796, 0, 0, 0);
		add_entry("comp4x_at_knee", 8'h15, 14798, -14798, 0, 0, 0);
		add_entry("comp4x_above_knee", 8'h17, 14800, -14800, 0, 0, 0);
		add_entry("comp4x_full", 8'h17, 32767, -32768, 0, 0, 0);
		add_entry("comp4x_mix", 8'h3c, 12000, -15000, 9000, -7000, 11000);
		add_entry("no_tone", 8'h30, 6000, -7000, 8000, -9000, 10000);
		add_entry("no_cd", 8'h28, 6000, -7000, 8000, -9000, 10000);
		add_entry("no_adpcm", 8'h18, 6000, -7000, 8000, -9000, 10000);

		for (i = 0; i < names.size() && !timed_out; i++) begin
			wb_access(1'b1, 4'(wb_pkg::CTRL_OFFSET), ctrls[i], rd, acks);
			{cdda_l, cdda_r, psg_l, psg_r, adpcm} = ins[i];
			repeat (audio_pkg::PIPE_LATENCY) @(negedge clk_sys);
			check_value(names[i], exps[i], {audio_l, audio_r});
		end

		////////////////////
		// Streaming of a new set every cycle with the 2x curve on
		base = names.size();
		for (i = 0; i < STREAM_LEN; i++)
			add_entry($sformatf("stream_%0d", i), 8'h3a, rand_sample(), rand_sample(),
				rand_sample(), rand_sample(), rand_sample());
		wb_access(1'b1, 4'(wb_pkg::CTRL_OFFSET), 8'h3a, rd, acks);
		for (i = 0; i < STREAM_LEN + audio_pkg::PIPE_LATENCY && !timed_out; i++) begin
			// Set entered PIPE_LATENCY falling edges ago
			if (i >= audio_pkg::PIPE_LATENCY)
				check_value(names[base + i - audio_pkg::PIPE_LATENCY],
					exps[base + i - audio_pkg::PIPE_LATENCY], {audio_l, audio_r});
			if (i < STREAM_LEN)
				{cdda_l, cdda_r, psg_l, psg_r, adpcm} = ins[base + i];
			@(negedge clk_sys);
		end

		$display("Checks: %0d passed, %0d failed", passes, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== wb_pkg.sv ====
// Wishbone control port definitions
// Bus widths, register map and the control byte layout

package wb_pkg;

	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;

	typedef logic [DATA_W-1:0] wb_data_t;

	// Control byte, lives in byte lane 0
	typedef logic [7:0] ctrl_t;

	// Word address of the control register
	localparam int CTRL_OFFSET = 0;

	////////////////////
	// Field positions
	localparam int CTRL_CDDA_BOOST_BIT = 0;
	localparam int CTRL_MBOOST_LSB     = 1;
	localparam int CTRL_PSG_EN_BIT     = 3;
	localparam int CTRL_CDDA_EN_BIT    = 4;
	localparam int CTRL_ADPCM_EN_BIT   = 5;

	// All sources on, no CD boost, no compression
	localparam ctrl_t CTRL_RESET = ctrl_t'((1 << CTRL_PSG_EN_BIT)
		| (1 << CTRL_CDDA_EN_BIT)
		| (1 << CTRL_ADPCM_EN_BIT));

endpackage
